// File: axi_cache_bridge.f
+incdir+common
+incdir+verif
common/axi_bridge_pkg.sv
common/wr_beat_if.sv
rd_path/axi_read_engine.sv
wr_path/write_line_buffer.sv
wr_path/axi_write_engine.sv
rtl/axi_cache_bridge.sv
verif/axi_slave_model.sv
verif/axi_cache_bridge_tb.sv

// File: common/axi_bridge_pkg.sv
`include "axi_bridge_settings.svh"

package axi_bridge_pkg;

	typedef logic [`AXI_ADDR_W-1:0] addr_t;
	typedef logic [`AXI_DATA_W-1:0] data_t;
	typedef logic [`LINE_W-1:0] line_t; // word 0 in the low bits
	typedef logic [`AXI_DATA_W/8-1:0] strb_t;

	typedef logic [3:0] axi_id_t;
	typedef logic [2:0] size_t; // log2 of bytes per beat
	typedef logic [$clog2(`LINE_BEATS)-1:0] beat_cnt_t;

	// read side FSM
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_RESP
	} rd_state_t;

	// write side FSM
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_t;

endpackage

// File: common/axi_bridge_settings.svh
`ifndef AXI_BRIDGE_SETTINGS_SVH
`define AXI_BRIDGE_SETTINGS_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// cache line geometry
`define LINE_BEATS 16
`define LINE_W 512

// arlen/awlen codes, beats minus one
`define BURST_LEN_LINE 4'd15
`define BURST_LEN_SINGLE 4'd0

// arburst/awburst codes
`define BURST_INCR 2'b01
`define BURST_FIXED 2'b00

// read ids, 0 for fetch and 1 for data
`define RD_ID_INST 4'd0
`define RD_ID_DATA 4'd1

`endif

// File: common/wr_beat_if.sv
`timescale 1ns/1ps

interface wr_beat_if
	import axi_bridge_pkg::*;
();

	logic  load;      // one cycle, on request accept
	logic  uncached;  // single word transfer
	line_t line_in;
	data_t word_in;
	logic  advance;   // W beat taken by the slave
	data_t cur_word;
	logic  last_beat;

	// write FSM side
	modport seq (output load, uncached, line_in, word_in, advance,
		input cur_word, last_beat);

	// line buffer side
	modport buff (input load, uncached, line_in, word_in, advance,
		output cur_word, last_beat);

endinterface

// File: rd_path/axi_read_engine.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module axi_read_engine
	import axi_bridge_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      ic_rd_req,
	input  addr_t     ic_rd_addr,
	input  size_t     ic_rd_size,
	input  logic      dc_rd_req,
	input  addr_t     dc_rd_addr,
	input  size_t     dc_rd_size,
	input  logic      uncached,
	input  logic      wr_pending,
	input  addr_t     wr_addr,
	output logic      ic_rd_rdy,
	output logic      dc_rd_rdy,
	output axi_id_t   arid,
	output addr_t     araddr,
	output logic [3:0] arlen,
	output size_t     arsize,
	output logic [1:0] arburst,
	output logic      arvalid,
	input  logic      arready,
	input  axi_id_t   rid,
	input  data_t     rdata,
	input  logic      rlast,
	input  logic      rvalid,
	output logic      ic_ret_valid,
	output logic      ic_ret_last,
	output logic      dc_ret_valid,
	output logic      dc_ret_last,
	output data_t     ret_data
);

	rd_state_t state;
	logic      ic_hit;
	logic      dc_hit;
	logic      ic_acc;
	logic      dc_acc;
	logic      r_beat;

	// a read may not overtake a write to the same address
	assign ic_hit = wr_pending && (ic_rd_addr == wr_addr);
	assign dc_hit = wr_pending && (dc_rd_addr == wr_addr);

	assign ic_rd_rdy = (state == RD_IDLE) && arready && !ic_hit;
	assign dc_rd_rdy = (state == RD_IDLE) && arready && !ic_rd_req && !dc_hit; // fetch first
	assign ic_acc = ic_rd_req && ic_rd_rdy;
	assign dc_acc = dc_rd_req && dc_rd_rdy;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= RD_IDLE;
		else
		begin
			case (state)
				RD_IDLE:
					if (ic_acc || dc_acc)
						state <= RD_ADDR;
				RD_ADDR:
					if (arready)
						state <= RD_RESP;
				RD_RESP:
					if (rvalid && rlast) // burst done
						state <= RD_IDLE;
				default:
					state <= RD_IDLE;
			endcase
		end
	end

	// AR payload, captured once so the cache may drop its inputs
	always_ff @(posedge clk)
	begin
		if (ic_acc)
		begin
			arid    <= `RD_ID_INST;
			araddr  <= ic_rd_addr;
			arsize  <= ic_rd_size;
			arlen   <= `BURST_LEN_LINE;
			arburst <= `BURST_INCR;
		end
		else if (dc_acc)
		begin
			arid    <= `RD_ID_DATA;
			araddr  <= dc_rd_addr;
			arsize  <= dc_rd_size;
			arlen   <= uncached ? `BURST_LEN_SINGLE : `BURST_LEN_LINE;
			arburst <= uncached ? `BURST_FIXED : `BURST_INCR;
		end
	end

	assign arvalid = (state == RD_ADDR);

	// route each beat by its id
	assign r_beat = (state == RD_RESP) && rvalid;
	assign ic_ret_valid = r_beat && (rid == `RD_ID_INST);
	assign ic_ret_last = ic_ret_valid && rlast;
	assign dc_ret_valid = r_beat && (rid == `RD_ID_DATA);
	assign dc_ret_last = dc_ret_valid && rlast;
	assign ret_data = rdata; // shared by both ports

endmodule

// File: rtl/axi_cache_bridge.sv
`timescale 1ns/1ps

module axi_cache_bridge
	import axi_bridge_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	// instruction cache read port
	input  logic       ic_rd_req,
	input  addr_t      ic_rd_addr,
	input  size_t      ic_rd_size,
	output logic       ic_rd_rdy,
	output logic       ic_ret_valid,
	output logic       ic_ret_last,
	// data cache ports
	input  logic       dc_rd_req,
	input  addr_t      dc_rd_addr,
	input  size_t      dc_rd_size,
	output logic       dc_rd_rdy,
	output logic       dc_ret_valid,
	output logic       dc_ret_last,
	output data_t      ret_data,
	input  logic       uncached,
	input  logic       dc_wr_req,
	input  addr_t      dc_wr_addr,
	input  size_t      dc_wr_size,
	input  strb_t      dc_wr_strb,
	input  line_t      dc_wr_line,
	input  data_t      dc_wr_word,
	output logic       dc_wr_rdy,
	// AXI read
	output axi_id_t    arid,
	output addr_t      araddr,
	output logic [3:0] arlen,
	output size_t      arsize,
	output logic [1:0] arburst,
	output logic       arvalid,
	input  logic       arready,
	input  axi_id_t    rid,
	input  data_t      rdata,
	input  logic       rlast,
	input  logic       rvalid,
	// AXI write
	output addr_t      awaddr,
	output logic [3:0] awlen,
	output size_t      awsize,
	output logic [1:0] awburst,
	output logic       awvalid,
	input  logic       awready,
	output data_t      wdata,
	output strb_t      wstrb,
	output logic       wlast,
	output logic       wvalid,
	input  logic       wready,
	input  logic       bvalid
);

	logic  wr_pending;
	addr_t wr_addr;

	wr_beat_if beat_if ();

	axi_read_engine u_rd (
		.clk, .rst,
		.ic_rd_req, .ic_rd_addr, .ic_rd_size,
		.dc_rd_req, .dc_rd_addr, .dc_rd_size, .uncached,
		.wr_pending, .wr_addr,
		.ic_rd_rdy, .dc_rd_rdy,
		.arid, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
		.rid, .rdata, .rlast, .rvalid,
		.ic_ret_valid, .ic_ret_last, .dc_ret_valid, .dc_ret_last, .ret_data
	);

	axi_write_engine u_wr (
		.clk, .rst,
		.dc_wr_req, .dc_wr_addr, .dc_wr_size, .dc_wr_strb,
		.dc_wr_line, .dc_wr_word, .uncached,
		.dc_wr_rdy, .wr_pending, .wr_addr,
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wstrb, .wlast, .wvalid, .wready, .bvalid,
		.beat (beat_if)
	);

	write_line_buffer u_wbuf (
		.clk,
		.rst,
		.beat (beat_if)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run with Verilator; pass only if the pass line is printed
verilator --binary --timing --top-module axi_cache_bridge_tb \
	-f axi_cache_bridge.f -o tb_sim || exit 1
out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qF "*** TEST PASSED ***" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: verif/tb_pattern.svh
`ifndef TB_PATTERN_SVH
`define TB_PATTERN_SVH

// power-up memory content of the slave model
// every address bit takes part, so no two words alias
function automatic logic [31:0] pattern_word(logic [31:0] addr);
	logic [31:0] mix;
	mix = addr * 32'h9e37_79b9;
	return {addr[15:0], addr[31:16]} ^ mix ^ 32'h5a5a_c3c3;
endfunction

`endif

// File: verif/axi_cache_bridge_tb.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"
`include "tb_pattern.svh"

module axi_cache_bridge_tb
	import axi_bridge_pkg::*;
();

	localparam int TIMEOUT = 2000;
	localparam logic [31:0] SEED = 32'h65b4;

	// address channel fields expected for one request
	typedef struct packed {
		axi_id_t    id;
		addr_t      addr;
		logic [3:0] len;
		logic [1:0] burst;
		size_t      size;
	} addr_req_t;

	logic       clk;
	logic       rst;
	logic       ic_rd_req;
	addr_t      ic_rd_addr;
	size_t      ic_rd_size;
	logic       ic_rd_rdy;
	logic       ic_ret_valid;
	logic       ic_ret_last;
	logic       dc_rd_req;
	addr_t      dc_rd_addr;
	size_t      dc_rd_size;
	logic       dc_rd_rdy;
	logic       dc_ret_valid;
	logic       dc_ret_last;
	data_t      ret_data;
	logic       uncached;
	logic       dc_wr_req;
	addr_t      dc_wr_addr;
	size_t      dc_wr_size;
	strb_t      dc_wr_strb;
	line_t      dc_wr_line;
	data_t      dc_wr_word;
	logic       dc_wr_rdy;
	axi_id_t    arid;
	addr_t      araddr;
	logic [3:0] arlen;
	size_t      arsize;
	logic [1:0] arburst;
	logic       arvalid;
	logic       arready;
	axi_id_t    rid;
	data_t      rdata;
	logic       rlast;
	logic       rvalid;
	addr_t      awaddr;
	logic [3:0] awlen;
	size_t      awsize;
	logic [1:0] awburst;
	logic       awvalid;
	logic       awready;
	data_t      wdata;
	strb_t      wstrb;
	logic       wlast;
	logic       wvalid;
	logic       wready;
	logic       bvalid;

	integer    seed;
	data_t     shadow [addr_t]; // words written so far
	addr_t     ic_exp [0:2047];
	logic      ic_exp_last [0:2047];
	addr_t     dc_exp [0:2047];
	logic      dc_exp_last [0:2047];
	int        ic_total = 0;
	int        dc_total = 0;
	int        ic_got = 0;
	int        dc_got = 0;
	time       ic_last_t = 0;
	time       dc_first_t = 0;
	logic      dc_in_burst = 1'b0;
	addr_req_t ar_exp [$]; // in issue order
	addr_req_t aw_exp [$];
	addr_req_t ar_want;
	addr_req_t aw_want;

	axi_cache_bridge i_dut (.*);

	axi_slave_model #(.SEED(SEED)) i_slave (.*);

	always #10 clk = ~clk;

	function automatic data_t merge_bytes(data_t old, data_t nw, strb_t s);
		data_t res;
		res = old;
		for (int i = 0; i < 4; i++)
			if (s[i])
				res[8*i +: 8] = nw[8*i +: 8];
		return res;
	endfunction

	// last written value or else the power-up pattern
	function automatic data_t expected_word(addr_t a);
		addr_t key;
		key = {a[31:2], 2'b00};
		if (shadow.exists(key))
			return shadow[key];
		return pattern_word(key);
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	// queue the expected beats, then raise the request
	task automatic begin_read(bit is_ic, addr_t a, bit unc);
		int n;
		addr_req_t req;
		n = unc ? 1 : `LINE_BEATS;
		req.id = is_ic ? `RD_ID_INST : `RD_ID_DATA;
		req.addr = a;
		req.len = unc ? `BURST_LEN_SINGLE : `BURST_LEN_LINE;
		req.burst = unc ? `BURST_FIXED : `BURST_INCR;
		req.size = is_ic ? ic_rd_size : dc_rd_size;
		ar_exp.push_back(req);
		for (int i = 0; i < n; i++)
		begin
			if (is_ic)
			begin
				ic_exp[ic_total] = a + 4 * i;
				ic_exp_last[ic_total] = (i == n - 1);
				ic_total++;
			end
			else
			begin
				dc_exp[dc_total] = a + 4 * i;
				dc_exp_last[dc_total] = (i == n - 1);
				dc_total++;
			end
		end
		if (is_ic)
		begin
			ic_rd_addr = a;
			ic_rd_req = 1'b1;
		end
		else
		begin
			dc_rd_addr = a;
			uncached = unc;
			dc_rd_req = 1'b1;
		end
	endtask

	task automatic wait_accept(bit is_ic);
		int n;
		bit seen;
		n = 0;
		seen = 0;
		while (!seen)
		begin
			@(negedge clk);
			if (is_ic ? ic_rd_rdy : dc_rd_rdy)
				seen = 1;
			else
			begin
				n++;
				if (n > TIMEOUT)
					abort_run("timeout: read request was never accepted");
			end
		end
		@(posedge clk);
		#1;
		if (is_ic)
			ic_rd_req = 1'b0;
		else
			dc_rd_req = 1'b0;
	endtask

	task automatic wait_reads_done();
		int n;
		n = 0;
		while (ic_got != ic_total || dc_got != dc_total)
		begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				abort_run("timeout: read data did not all return");
		end
		#1;
	endtask

	task automatic read_once(bit is_ic, addr_t a, bit unc);
		begin_read(is_ic, a, unc);
		wait_accept(is_ic);
		wait_reads_done();
	endtask

	task automatic write_once(addr_t a, bit unc, data_t w, strb_t s, line_t l);
		int n;
		bit seen;
		addr_req_t req;
		if (unc)
			shadow[{a[31:2], 2'b00}] = merge_bytes(expected_word(a), w, s);
		else
			for (int i = 0; i < `LINE_BEATS; i++)
				shadow[a + 4 * i] = l[32*i +: 32]; // word 0 first
		req.id = '0;
		req.addr = a;
		req.len = unc ? `BURST_LEN_SINGLE : `BURST_LEN_LINE;
		req.burst = unc ? `BURST_FIXED : `BURST_INCR;
		req.size = dc_wr_size;
		aw_exp.push_back(req);
		dc_wr_addr = a;
		dc_wr_strb = s;
		dc_wr_word = w;
		dc_wr_line = l;
		uncached = unc;
		dc_wr_req = 1'b1;
		n = 0;
		seen = 0;
		while (!seen)
		begin
			@(negedge clk);
			if (dc_wr_rdy)
				seen = 1;
			else
			begin
				n++;
				if (n > TIMEOUT)
					abort_run("timeout: write request was never accepted");
			end
		end
		@(posedge clk);
		#1;
		dc_wr_req = 1'b0;
		// engine back in idle after the B response
		n = 0;
		seen = 0;
		while (!seen)
		begin
			@(negedge clk);
			if (dc_wr_rdy)
				seen = 1;
			else
			begin
				n++;
				if (n > TIMEOUT)
					abort_run("timeout: write did not complete");
			end
		end
		@(posedge clk);
		#1;
	endtask

	// compare every returned beat
	always @(negedge clk)
	begin
		if (rst)
		begin
			if (ic_ret_valid && dc_ret_valid)
				abort_run("both return ports were valid in the same cycle");
			if (ic_ret_valid)
			begin
				if (ic_got >= ic_total)
					abort_run("instruction return beat with no read outstanding");
				check_eq("ic ret_data", ret_data, expected_word(ic_exp[ic_got]));
				check_eq("ic_ret_last", 32'(ic_ret_last), 32'(ic_exp_last[ic_got]));
				if (ic_ret_last)
					ic_last_t = $time;
				ic_got++;
			end
			if (dc_ret_valid)
			begin
				if (dc_got >= dc_total)
					abort_run("data return beat with no read outstanding");
				check_eq("dc ret_data", ret_data, expected_word(dc_exp[dc_got]));
				check_eq("dc_ret_last", 32'(dc_ret_last), 32'(dc_exp_last[dc_got]));
				if (!dc_in_burst)
					dc_first_t = $time;
				dc_in_burst = !dc_ret_last;
				dc_got++;
			end
		end
	end

	// address phases against the request that caused them
	always @(negedge clk)
	begin
		if (rst && arvalid && arready)
		begin
			if (ar_exp.size() == 0)
				abort_run("read address issued with no read request");
			ar_want = ar_exp.pop_front();
			check_eq("arid", 32'(arid), 32'(ar_want.id));
			check_eq("araddr", araddr, ar_want.addr);
			check_eq("arlen", 32'(arlen), 32'(ar_want.len));
			check_eq("arburst", 32'(arburst), 32'(ar_want.burst));
			check_eq("arsize", 32'(arsize), 32'(ar_want.size));
		end
		if (rst && awvalid && awready)
		begin
			if (aw_exp.size() == 0)
				abort_run("write address issued with no write request");
			aw_want = aw_exp.pop_front();
			check_eq("awaddr", awaddr, aw_want.addr);
			check_eq("awlen", 32'(awlen), 32'(aw_want.len));
			check_eq("awburst", 32'(awburst), 32'(aw_want.burst));
			check_eq("awsize", 32'(awsize), 32'(aw_want.size));
		end
	end

	initial
	begin
		integer rnd;
		line_t  line;
		addr_t  line_a;
		addr_t  word_a;
		strb_t  s;
		data_t  w;
		seed = SEED;
		clk = 1'b0;
		rst = 1'b0;
		ic_rd_req = 1'b0;
		ic_rd_addr = '0;
		ic_rd_size = 3'd2;
		dc_rd_req = 1'b0;
		dc_rd_addr = '0;
		dc_rd_size = 3'd2;
		uncached = 1'b0;
		dc_wr_req = 1'b0;
		dc_wr_addr = '0;
		dc_wr_size = 3'd2;
		dc_wr_strb = '0;
		dc_wr_line = '0;
		dc_wr_word = '0;
		repeat (9) @(posedge clk);
		@(negedge clk);
		check_eq("arvalid", 32'(arvalid), 32'd0);
		check_eq("awvalid", 32'(awvalid), 32'd0);
		check_eq("wvalid", 32'(wvalid), 32'd0);
		check_eq("ic_ret_valid", 32'(ic_ret_valid), 32'd0);
		check_eq("dc_ret_valid", 32'(dc_ret_valid), 32'd0);
		@(posedge clk);
		#1;
		rst = 1'b1;

		read_once(1'b1, 32'h0000_1000, 1'b0); // fetch line
		read_once(1'b0, 32'h0000_2044, 1'b1); // single uncached word

		for (int i = 0; i < `LINE_BEATS; i++)
		begin
			rnd = $random(seed);
			line[32*i +: 32] = rnd;
		end
		write_once(32'h0000_3000, 1'b0, '0, 4'hf, line);
		read_once(1'b0, 32'h0000_3000, 1'b0);

		write_once(32'h0000_4008, 1'b1, 32'hdead_beef, 4'b0101, '0);
		read_once(1'b0, 32'h0000_4008, 1'b1);

		// fetch wins when both ports ask in the same cycle
		begin_read(1'b1, 32'h0000_5000, 1'b0);
		begin_read(1'b0, 32'h0000_5400, 1'b0);
		wait_accept(1'b1);
		wait_accept(1'b0);
		wait_reads_done();
		check_eq("data return after fetch", 32'(dc_first_t > ic_last_t), 32'd1);

		for (int k = 0; k < 40; k++)
		begin
			rnd = $random(seed);
			line_a = 32'h0001_0000 + 32'(rnd[6:4]) * 32'd64;
			word_a = line_a + 32'(rnd[10:7]) * 32'd4;
			s = (rnd[14:11] == 4'd0) ? 4'b1000 : rnd[14:11];
			w = $random(seed);
			case (rnd[2:0])
				3'd0, 3'd1: read_once(1'b1, line_a, 1'b0);
				3'd2: read_once(1'b0, line_a, 1'b0);
				3'd3: read_once(1'b0, word_a, 1'b1);
				3'd4, 3'd5:
				begin
					for (int i = 0; i < `LINE_BEATS; i++)
					begin
						rnd = $random(seed);
						line[32*i +: 32] = rnd;
					end
					write_once(line_a, 1'b0, '0, 4'hf, line);
				end
				default: write_once(word_a, 1'b1, w, s, '0);
			endcase
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: verif/axi_slave_model.sv
`timescale 1ns/1ps
`include "tb_pattern.svh"

module axi_slave_model #(
	parameter logic [31:0] SEED = 32'h65b4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [3:0]  arid,
	input  logic [31:0] araddr,
	input  logic [3:0]  arlen,
	input  logic [1:0]  arburst,
	input  logic        arvalid,
	output logic        arready,
	output logic [3:0]  rid,
	output logic [31:0] rdata,
	output logic        rlast,
	output logic        rvalid,
	input  logic [31:0] awaddr,
	input  logic [1:0]  awburst,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wlast,
	input  logic        wvalid,
	output logic        wready,
	output logic        bvalid
);

	integer      seed;
	integer      rnd;
	logic [31:0] mem [logic [31:0]];
	logic        rd_busy;
	logic [31:0] rd_addr;
	logic [3:0]  rd_left;
	logic [3:0]  rd_id;
	logic        rd_incr;
	logic [1:0]  wr_phase; // 0 addr, 1 data, 2 resp
	logic [31:0] wr_ptr;
	logic        wr_incr;

	initial seed = SEED;

	function automatic logic [31:0] mem_word(logic [31:0] a);
		logic [31:0] key;
		key = {a[31:2], 2'b00};
		if (mem.exists(key))
			return mem[key];
		return pattern_word(key);
	endfunction

	function automatic logic [31:0] strobe_merge(logic [31:0] old, logic [31:0] nw,
		logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++)
			if (strb[i])
				res[8*i +: 8] = nw[8*i +: 8];
		return res;
	endfunction

	always @(posedge clk)
	begin
		rnd = $random(seed);
		if (!rst)
		begin
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			rlast    <= 1'b0;
			awready  <= 1'b0;
			wready   <= 1'b0;
			bvalid   <= 1'b0;
			rd_busy  <= 1'b0;
			wr_phase <= 2'd0;
		end
		else
		begin
			// read channel
			if (!rd_busy)
			begin
				rvalid <= 1'b0;
				rlast  <= 1'b0;
				if (arvalid && arready)
				begin
					rd_busy <= 1'b1;
					rd_addr <= araddr;
					rd_left <= arlen;
					rd_id   <= arid;
					rd_incr <= (arburst == 2'b01);
					arready <= 1'b0;
				end
				else
					arready <= rnd[0];
			end
			else if (rnd[2:1] != 2'b00) // random gaps between beats
			begin
				rvalid <= 1'b1;
				rid    <= rd_id;
				rdata  <= mem_word(rd_addr);
				rlast  <= (rd_left == 4'd0);
				if (rd_left == 4'd0)
					rd_busy <= 1'b0;
				rd_left <= rd_left - 4'd1;
				if (rd_incr)
					rd_addr <= rd_addr + 32'd4;
			end
			else
				rvalid <= 1'b0;

			// write channel
			case (wr_phase)
				2'd0:
				begin
					bvalid <= 1'b0;
					if (awvalid && awready)
					begin
						wr_phase <= 2'd1;
						wr_ptr   <= awaddr;
						wr_incr  <= (awburst == 2'b01);
						awready  <= 1'b0;
						wready   <= rnd[3];
					end
					else
						awready <= rnd[4];
				end
				2'd1:
				begin
					if (wvalid && wready)
					begin
						mem[{wr_ptr[31:2], 2'b00}] = strobe_merge(mem_word(wr_ptr), wdata, wstrb);
						if (wr_incr)
							wr_ptr <= wr_ptr + 32'd4;
						if (wlast)
						begin
							wr_phase <= 2'd2;
							wready   <= 1'b0;
							bvalid   <= 1'b1;
						end
						else
							wready <= rnd[5];
					end
					else
						wready <= rnd[5];
				end
				default:
				begin
					bvalid   <= 1'b0; // one cycle response
					wr_phase <= 2'd0;
				end
			endcase
		end
	end

endmodule

// File: wr_path/axi_write_engine.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module axi_write_engine
	import axi_bridge_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       dc_wr_req,
	input  addr_t      dc_wr_addr,
	input  size_t      dc_wr_size,
	input  strb_t      dc_wr_strb,
	input  line_t      dc_wr_line,
	input  data_t      dc_wr_word,
	input  logic       uncached,
	output logic       dc_wr_rdy,
	output logic       wr_pending,
	output addr_t      wr_addr,
	output addr_t      awaddr,
	output logic [3:0] awlen,
	output size_t      awsize,
	output logic [1:0] awburst,
	output logic       awvalid,
	input  logic       awready,
	output data_t      wdata,
	output strb_t      wstrb,
	output logic       wlast,
	output logic       wvalid,
	input  logic       wready,
	input  logic       bvalid,
	wr_beat_if.seq     beat
);

	wr_state_t state;
	logic      acc;
	logic      unc_q;

	assign dc_wr_rdy = (state == WR_IDLE);
	assign acc = dc_wr_req && dc_wr_rdy;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= WR_IDLE;
		else
		begin
			case (state)
				WR_IDLE:
					if (acc)
						state <= WR_ADDR;
				WR_ADDR:
					if (awready)
						state <= WR_DATA;
				WR_DATA:
					if (wready && beat.last_beat)
						state <= WR_RESP;
				WR_RESP:
					if (bvalid)
						state <= WR_IDLE;
				default:
					state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (acc)
		begin
			awaddr  <= dc_wr_addr;
			awsize  <= dc_wr_size;
			awlen   <= uncached ? `BURST_LEN_SINGLE : `BURST_LEN_LINE;
			awburst <= uncached ? `BURST_FIXED : `BURST_INCR;
			wstrb   <= uncached ? dc_wr_strb : '1; // full words for a line
			unc_q   <= uncached;
		end
	end

	assign awvalid = (state == WR_ADDR);
	assign wvalid = (state == WR_DATA);
	assign wdata = beat.cur_word;
	assign wlast = beat.last_beat;

	assign wr_pending = (state != WR_IDLE);
	assign wr_addr = awaddr;

	// line buffer control
	assign beat.load = acc;
	assign beat.uncached = dc_wr_rdy ? uncached : unc_q; // held once accepted
	assign beat.line_in = dc_wr_line;
	assign beat.word_in = dc_wr_word;
	assign beat.advance = wvalid && wready;

endmodule

// File: wr_path/write_line_buffer.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module write_line_buffer
	import axi_bridge_pkg::*;
(
	input logic     clk,
	input logic     rst,
	wr_beat_if.buff beat
);

	line_t     line_q;
	beat_cnt_t cnt;

	// beat counter
	always_ff @(posedge clk)
	begin
		if (!rst)
			cnt <= '0;
		else if (beat.load)
			cnt <= '0;
		else if (beat.advance)
			cnt <= cnt + 1'b1;
	end

	// payload shift register
	always_ff @(posedge clk)
	begin
		if (beat.load)
		begin
			if (beat.uncached)
				line_q <= {{(`LINE_W-`AXI_DATA_W){1'b0}}, beat.word_in};
			else
				line_q <= beat.line_in;
		end
		else if (beat.advance)
			line_q <= line_q >> `AXI_DATA_W; // next word into the low slot
	end

	assign beat.cur_word = line_q[`AXI_DATA_W-1:0];

	// single word is last at once
	assign beat.last_beat = beat.uncached || (cnt == beat_cnt_t'(`LINE_BEATS - 1));

endmodule
